//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --timescale 1ns/1ps \
  --top-module turf_wars_tb \
  -f turf_wars.f \
  -Mdir obj_dir -o turf_wars_sim \
  > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/turf_wars_sim > sim.log 2>&1
cat sim.log

grep -q "FAIL: see errors above" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "PASS: all tests" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
exit 0

//--- source/board_clear.sv
`timescale 1ns/1ps
`default_nettype none

`include "turf_params.svh"

module board_clear
  import game_types_pkg::*;
  import game_ctrl_pkg::*;
(
  input  wire logic CLOCK_50,
  input  wire logic arst_n,
  input  draw_cmd_t cmd,
  output pos_u      sweep_pos,
  output logic      wait_done,
  output logic      sweep_last
);

  localparam int WAIT_W = $clog2(`CLEAR_WAIT_CYCLES + 1);

  logic [WAIT_W-1:0] wait_cnt;

  // Per-pixel wait, loaded when the pixel is plotted
  always_ff @(posedge CLOCK_50 or negedge arst_n)
  begin
    if (!arst_n)
      wait_cnt <= '0;
    else if (cmd.sweep_plot)
      wait_cnt <= WAIT_W'(`CLEAR_WAIT_CYCLES - 1);
    else if (cmd.sweep_wait && wait_cnt != '0)
      wait_cnt <= wait_cnt - 1'b1;
  end

  assign wait_done = (wait_cnt == '0);

  // Last point of the sweep, checked on the x/y view
  assign sweep_last = (sweep_pos.xy.x == 8'(`SWEEP_LAST_X)) &&
                      (sweep_pos.xy.y == 7'(`SWEEP_LAST_Y));

  // Linear address steps through every y of a column, then the next x
  always_ff @(posedge CLOCK_50 or negedge arst_n)
  begin
    if (!arst_n)
      sweep_pos.addr <= '0;
    else if (cmd.sweep_inc)
    begin
      if (sweep_last)
        sweep_pos.addr <= '0; // Ready for the next sweep
      else
        sweep_pos.addr <= sweep_pos.addr + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- source/game_ctrl_pkg.sv
`default_nettype none

package game_ctrl_pkg;

  typedef enum logic [4:0] {
    START      = 5'd0,
    CLEAR      = 5'd1,
    CLEAR_WAIT = 5'd2,
    CLEAR_INC  = 5'd3,
    DRAW_P1    = 5'd4, // Everything from here on counts as started
    DRAW_P2    = 5'd5,
    DRAW_P3    = 5'd6,
    DRAW_P4    = 5'd7,
    DRAW_TIMER = 5'd8,
    END_CLEAR  = 5'd9,
    END_WAIT   = 5'd10,
    END_INC    = 5'd11,
    HALT       = 5'd12
  } game_state_e;

  // Decoded per state, 10 bits
  typedef struct packed {
    logic [3:0] player_sel;  // One-hot, bit 0 is player 1
    logic       timer_px;
    logic       sweep_plot;  // CLEAR or END_CLEAR
    logic       sweep_wait;
    logic       sweep_inc;
    logic       sweep_black; // Start sweep, not end sweep
    logic       started;
  } draw_cmd_t;

endpackage

`default_nettype wire

//--- source/game_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "turf_params.svh"

module game_fsm
  import game_ctrl_pkg::*;
(
  input  wire logic CLOCK_50,
  input  wire logic arst_n,
  input  wire logic start_key,
  input  wire logic running,
  input  wire logic wait_done,
  input  wire logic sweep_last,
  output draw_cmd_t cmd
);

  game_state_e state;
  game_state_e state_next;

  always_ff @(posedge CLOCK_50 or negedge arst_n)
  begin
    if (!arst_n)
      state <= START;
    else
      state <= state_next;
  end

  always_comb
  begin
    state_next = state;
    unique case (state)
      START:
        state_next = start_key ? CLEAR : START;

      // Board to black before play
      CLEAR:      state_next = CLEAR_WAIT;
      CLEAR_WAIT: state_next = wait_done ? CLEAR_INC : CLEAR_WAIT;
      CLEAR_INC:  state_next = sweep_last ? DRAW_P1 : CLEAR;

      // One round of the play loop
      DRAW_P1:    state_next = DRAW_P2;
      DRAW_P2:    state_next = DRAW_P3;
      DRAW_P3:    state_next = DRAW_P4;
      DRAW_P4:    state_next = DRAW_TIMER;
      DRAW_TIMER: state_next = running ? DRAW_P1 : END_CLEAR;

      // Board to white once the timer has run out
      END_CLEAR:  state_next = END_WAIT;
      END_WAIT:   state_next = wait_done ? END_INC : END_WAIT;
      END_INC:    state_next = sweep_last ? HALT : END_CLEAR;

      HALT:       state_next = HALT; // Left only through reset
      default:    state_next = START;
    endcase
  end

  // Moore outputs straight from the state register
  always_comb
  begin
    cmd = '0;
    unique case (state)
      CLEAR:
      begin
        cmd.sweep_plot  = 1'b1;
        cmd.sweep_black = 1'b1;
      end
      CLEAR_WAIT:
      begin
        cmd.sweep_wait  = 1'b1;
        cmd.sweep_black = 1'b1;
      end
      CLEAR_INC:
      begin
        cmd.sweep_inc   = 1'b1;
        cmd.sweep_black = 1'b1;
      end
      DRAW_P1:    cmd.player_sel = 4'b0001;
      DRAW_P2:    cmd.player_sel = 4'b0010;
      DRAW_P3:    cmd.player_sel = 4'b0100;
      DRAW_P4:    cmd.player_sel = 4'b1000;
      DRAW_TIMER: cmd.timer_px   = 1'b1;
      END_CLEAR:  cmd.sweep_plot = 1'b1;
      END_WAIT:   cmd.sweep_wait = 1'b1;
      END_INC:    cmd.sweep_inc  = 1'b1;
      default:    cmd = '0;
    endcase
    cmd.started = (state >= DRAW_P1); // Play loop, end sweep and halt
  end

endmodule

`default_nettype wire

//--- source/game_types_pkg.sv
`default_nettype none

package game_types_pkg;

  // One bit per RGB channel
  typedef logic [2:0] colour_t;

  localparam colour_t COLOUR_BLACK = 3'b000;
  localparam colour_t COLOUR_WHITE = 3'b111;

  typedef struct packed {
    logic [7:0] x; // Column, upper bits
    logic [6:0] y; // Row, lower bits
  } pos_xy_t;

  // Same word seen as a screen point or as a linear sweep address
  typedef union packed {
    pos_xy_t     xy;
    logic [14:0] addr;
  } pos_u;

  // One pixel write toward the frame buffer, 19 bits
  typedef struct packed {
    logic    plot;
    pos_u    pos;
    colour_t colour;
  } pixel_t;

endpackage

`default_nettype wire

//--- source/pixel_writer.sv
`timescale 1ns/1ps
`default_nettype none

`include "turf_params.svh"

module pixel_writer
  import game_types_pkg::*;
  import game_ctrl_pkg::*;
(
  input  wire logic       CLOCK_50,
  input  wire logic       arst_n,
  input  draw_cmd_t       cmd,
  input  pos_u [3:0]      player_pos,
  input  pos_u            sweep_pos,
  input  wire logic [7:0] bar_x,
  output pixel_t          pixel
);

  // Player colours, index 0 is player 1
  localparam colour_t PLAYER_COLOUR [4] = '{3'b001, 3'b010, 3'b100, 3'b110};

  logic    plot_d;
  pos_u    pos_d;
  colour_t colour_d;

  logic    plot_q;
  pos_u    pos_q;
  colour_t colour_q;

  always_comb
  begin
    plot_d   = 1'b0;
    pos_d    = sweep_pos;
    colour_d = COLOUR_BLACK;
    if (cmd.sweep_plot)
    begin
      plot_d   = 1'b1;
      colour_d = cmd.sweep_black ? COLOUR_BLACK : COLOUR_WHITE;
    end
    else if (cmd.timer_px)
    begin
      plot_d      = 1'b1;
      pos_d.xy.x  = bar_x;
      pos_d.xy.y  = 7'(`TIMER_ROW); // Bottom row
      colour_d    = COLOUR_WHITE;
    end
    else
    begin
      for (int i = 0; i < 4; i++)
      begin
        if (cmd.player_sel[i])
        begin
          plot_d   = 1'b1;
          pos_d    = player_pos[i];
          colour_d = PLAYER_COLOUR[i];
        end
      end
    end
  end

  always_ff @(posedge CLOCK_50 or negedge arst_n)
  begin
    if (!arst_n)
      plot_q <= 1'b0;
    else
      plot_q <= plot_d;
  end

  // Position and colour of the pixel being written
  always_ff @(posedge CLOCK_50)
  begin
    pos_q    <= pos_d;
    colour_q <= colour_d;
  end

  assign pixel = '{plot: plot_q, pos: pos_q, colour: colour_q};

endmodule

`default_nettype wire

//--- source/timer_bar.sv
`timescale 1ns/1ps
`default_nettype none

`include "turf_params.svh"

module timer_bar
  import game_ctrl_pkg::*;
(
  input  wire logic  CLOCK_50,
  input  wire logic  arst_n,
  input  draw_cmd_t  cmd,
  output logic [7:0] bar_x,
  output logic       running
);

  localparam int DIV_W = $clog2(`TIMER_TICK_DIV + 1);

  logic [DIV_W-1:0] div_cnt;
  logic             tick;
  logic [7:0]       bar_next;

  assign tick     = cmd.started && (div_cnt == DIV_W'(`TIMER_TICK_DIV - 1));
  assign bar_next = bar_x + 1'b1;

  // Prescaler runs only once play has begun
  always_ff @(posedge CLOCK_50 or negedge arst_n)
  begin
    if (!arst_n)
      div_cnt <= '0;
    else if (tick)
      div_cnt <= '0;
    else if (cmd.started)
      div_cnt <= div_cnt + 1'b1;
  end

  // Column and flag move on the same edge
  always_ff @(posedge CLOCK_50 or negedge arst_n)
  begin
    if (!arst_n)
    begin
      bar_x   <= '0;
      running <= 1'b1;
    end
    else if (tick && running)
    begin
      bar_x <= bar_next;
      if (bar_next >= 8'(`TIMER_END_X))
        running <= 1'b0; // Sticky until reset
    end
  end

endmodule

`default_nettype wire

//--- source/turf_params.svh
`ifndef TURF_PARAMS_SVH
`define TURF_PARAMS_SVH

// Visible area of the frame buffer
`define SCREEN_W 160
`define SCREEN_H 120

// Last address of a whole-board sweep
// y runs over the full 7-bit range
`define SWEEP_LAST_X 159
`define SWEEP_LAST_Y 127

// Timer bar along the bottom row
`define TIMER_ROW 119
`define TIMER_END_X 158 // Game stops here

// Wait cycles per swept pixel, short for simulation
`define CLEAR_WAIT_CYCLES 2

// CLOCK_50 cycles per timer tick
`define TIMER_TICK_DIV 64

`endif

//--- source/turf_wars_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "turf_params.svh"

module turf_wars_top
  import game_types_pkg::*;
  import game_ctrl_pkg::*;
(
  input  wire logic CLOCK_50,
  input  wire logic arst_n,
  input  wire logic start_key,
  input  pos_u [3:0] player_pos, // Index 0 is player 1
  output pixel_t    pixel
);

  draw_cmd_t  cmd;
  pos_u       sweep_pos;
  logic       wait_done;
  logic       sweep_last;
  logic       running;
  logic [7:0] bar_x;

  game_fsm u_fsm (
    .CLOCK_50   (CLOCK_50),
    .arst_n     (arst_n),
    .start_key  (start_key),
    .running    (running),
    .wait_done  (wait_done),
    .sweep_last (sweep_last),
    .cmd        (cmd)
  );

  board_clear u_clear (
    .CLOCK_50   (CLOCK_50),
    .arst_n     (arst_n),
    .cmd        (cmd),
    .sweep_pos  (sweep_pos),
    .wait_done  (wait_done),
    .sweep_last (sweep_last)
  );

  timer_bar u_timer (
    .CLOCK_50 (CLOCK_50),
    .arst_n   (arst_n),
    .cmd      (cmd),
    .bar_x    (bar_x),
    .running  (running)
  );

  pixel_writer u_writer (
    .CLOCK_50   (CLOCK_50),
    .arst_n     (arst_n),
    .cmd        (cmd),
    .player_pos (player_pos),
    .sweep_pos  (sweep_pos),
    .bar_x      (bar_x),
    .pixel      (pixel)
  );

endmodule

`default_nettype wire

//--- turf_wars.f
+incdir+source
source/game_types_pkg.sv
source/game_ctrl_pkg.sv
source/game_fsm.sv
source/board_clear.sv
source/timer_bar.sv
source/pixel_writer.sv
source/turf_wars_top.sv
verification/turf_wars_tb.sv

//--- verification/turf_wars_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "turf_params.svh"

module turf_wars_tb
  import game_types_pkg::*;
();

  localparam int unsigned SWEEP_PIXELS = (`SWEEP_LAST_X + 1) * (`SWEEP_LAST_Y + 1);
  localparam int unsigned PIXEL_CYCLES = `CLEAR_WAIT_CYCLES + 2; // CLEAR, waits, INC
  localparam int unsigned TIMEOUT_CYCLES = 2 * SWEEP_PIXELS * PIXEL_CYCLES +
                                           (`TIMER_END_X + 2) * `TIMER_TICK_DIV + 20000;

  localparam colour_t BLACK = 3'b000;
  localparam colour_t WHITE = 3'b111;
  localparam colour_t PLAYER_COLOURS [4] = '{3'b001, 3'b010, 3'b100, 3'b110};

  logic       CLOCK_50 = 1'b0;
  logic       arst_n;
  logic       start_key;
  pos_u [3:0] player_pos;
  pixel_t     pixel;

  pos_u [3:0]  exp_pos;        // Positions the next round should show
  int unsigned cycle_cnt = 0;
  int unsigned last_plot_cyc = 0;

  turf_wars_top u_dut (
    .CLOCK_50   (CLOCK_50),
    .arst_n     (arst_n),
    .start_key  (start_key),
    .player_pos (player_pos),
    .pixel      (pixel)
  );

  always #5 CLOCK_50 = ~CLOCK_50;

  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic stop_run(input string why);
    $display("ERROR: %s", why);
    abort_run();
  endtask

  task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
    abort_run();
  endtask

  task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else mismatch(name, got, exp);
  endtask

  // Pixel monitor and watchdog on the rising edge
  always @(posedge CLOCK_50)
  begin
    cycle_cnt = cycle_cnt + 1;
    assert (arst_n !== 1'b1 || !$isunknown(pixel.plot))
    else stop_run("pixel.plot is unknown after reset");
    if (cycle_cnt >= TIMEOUT_CYCLES)
      stop_run($sformatf("timeout, no end of the game after %0d cycles", cycle_cnt));
  end

  task automatic apply_reset();
    @(negedge CLOCK_50);
    arst_n = 1'b0;
    repeat (5) @(negedge CLOCK_50);
    arst_n = 1'b1;
  endtask

  // Next plotted pixel and its distance in cycles from the previous one
  task automatic wait_plot(output pixel_t px, output int unsigned gap);
    do
    begin
      @(negedge CLOCK_50);
    end
    while (pixel.plot !== 1'b1);
    px = pixel;
    gap = cycle_cnt - last_plot_cyc;
    last_plot_cyc = cycle_cnt;
  endtask

  task automatic pulse_start();
    start_key = 1'b1;
    last_plot_cyc = cycle_cnt;
    @(negedge CLOCK_50);
    start_key = 1'b0;
  endtask

  task automatic shuffle_players();
    int i;
    for (i = 0; i < 4; i++)
    begin
      exp_pos[i].xy.x = 8'($urandom % `SCREEN_W);
      exp_pos[i].xy.y = 7'($urandom % `SCREEN_H);
    end
    player_pos = exp_pos;
  endtask

  task automatic idle_quiet(input int cycles, input logic key);
    start_key = key;
    repeat (cycles)
    begin
      @(negedge CLOCK_50);
      assert (pixel.plot === 1'b0) else mismatch("pixel.plot", 32'(pixel.plot), 32'h0);
    end
    start_key = 1'b0;
  endtask

  // Linear addresses in order, y in the low bits
  task automatic sweep_run(input colour_t colour, input int unsigned count,
                           input int unsigned first_gap);
    pixel_t      px;
    int unsigned gap;
    int unsigned i;
    for (i = 0; i < count; i++)
    begin
      wait_plot(px, gap);
      expect_eq("plot spacing", gap, (i == 0) ? first_gap : PIXEL_CYCLES);
      expect_eq("pixel.pos.addr", 32'(px.pos.addr), i);
      expect_eq("pixel.colour", 32'(px.colour), 32'(colour));
    end
  endtask

  task automatic midgame_reset();
    pulse_start();
    sweep_run(BLACK, 10, 2);
    apply_reset();
    idle_quiet(100, 1'b0);
  endtask

  task automatic start_sweep();
    pulse_start();
    sweep_run(BLACK, SWEEP_PIXELS, 2); // Start seen, then CLEAR, then plot
  endtask

  task automatic play_rounds();
    pixel_t      px;
    int unsigned gap;
    int          p;
    int          rounds;
    logic [7:0]  timer_x;
    logic [7:0]  prev_x;
    rounds = 0;
    prev_x = 8'd0;
    timer_x = 8'd0;
    while (timer_x < 8'(`TIMER_END_X) || rounds == 0)
    begin
      for (p = 0; p < 4; p++)
      begin
        wait_plot(px, gap);
        expect_eq("plot spacing", gap, (rounds == 0 && p == 0) ? PIXEL_CYCLES : 1);
        expect_eq("pixel.pos.xy.x", 32'(px.pos.xy.x), 32'(exp_pos[p].xy.x));
        expect_eq("pixel.pos.xy.y", 32'(px.pos.xy.y), 32'(exp_pos[p].xy.y));
        expect_eq("pixel.colour", 32'(px.colour), 32'(PLAYER_COLOURS[p]));
        if (p == 3)
          shuffle_players(); // P4 is registered, next P1 not yet
      end
      wait_plot(px, gap);
      expect_eq("plot spacing", gap, 1);
      expect_eq("pixel.pos.xy.y", 32'(px.pos.xy.y), `TIMER_ROW);
      expect_eq("pixel.colour", 32'(px.colour), 32'(WHITE));
      timer_x = px.pos.xy.x;
      if (rounds == 0)
        expect_eq("timer pixel x", 32'(timer_x), 32'h0);
      assert (timer_x >= prev_x) else stop_run("timer bar moved backward");
      assert (timer_x - prev_x <= 8'd1) else stop_run("timer bar skipped a column");
      prev_x = timer_x;
      rounds++;
    end
    $display("Play loop ran %0d rounds", rounds);
  endtask

  task automatic end_sweep();
    sweep_run(WHITE, SWEEP_PIXELS, 1); // END_CLEAR right after DRAW_TIMER
  endtask

  initial
  begin
    arst_n = 1'b0;
    start_key = 1'b0;
    player_pos = '0;
    exp_pos = '0;
    void'($urandom(36));
    apply_reset();
    idle_quiet(100, 1'b0);
    midgame_reset();
    shuffle_players();
    start_sweep();
    play_rounds();
    end_sweep();
    idle_quiet(1000, 1'b1); // HALT ignores the start key
    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire
